//--- hdl/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Bus widths.
`define ADDR_W 32
`define DATA_W 32

// Address window of the peripheral.
`define UART_BASE_ADDR 32'h2000_0000
`define UART_MASK_ADDR 32'h0000_000F

// Width of the register offset inside the window.
`define UART_OFF_W 4

// Both FIFOs, must be a power of two.
`define FIFO_DEPTH 32

// Baud divisor field width.
`define BAUD_W 16

// One serial data byte.
`define BYTE_W 8

`endif

//--- hdl/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

    // Load/store port request.
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic               write;
    } bus_req_t;

    typedef struct packed {
        logic [`BAUD_W-1:0]         baud_div;
        logic [`DATA_W-`BAUD_W-3:0] rsvd;     // Reads back as zero.
        logic                       rx_en;
        logic                       tx_en;
    } ctrl_reg_t;

    typedef struct packed {
        logic rx_empty;
        logic rx_full;
        logic tx_empty;
        logic tx_full;
    } status_t;

    typedef enum logic [`UART_OFF_W-1:0] {
        REG_CTRL   = 4'h0,
        REG_STATUS = 4'h4,
        REG_RDATA  = 4'h8,
        REG_WDATA  = 4'hC
    } reg_off_e;

    // Bus side wait states.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_DATA,
        ST_WAIT_SPACE
    } ctrl_state_e;

    // Serial frame position, shared by receiver and transmitter.
    typedef enum logic [1:0] {
        LN_IDLE,
        LN_START,
        LN_DATA,
        LN_STOP
    } line_state_e;

endpackage

//--- hdl/sync_fifo.sv
module sync_fifo #(
    parameter int DATA_W = 8,
    parameter int DEPTH  = 32
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [DATA_W-1:0] data_i,
    input  logic              wr_en_i,
    input  logic              rd_en_i,
    output logic [DATA_W-1:0] data_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem_q [DEPTH];
    logic [PTR_W:0]    wr_ptr_q; // Top bit tracks the wrap.
    logic [PTR_W:0]    rd_ptr_q;

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_ptr_q[PTR_W-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    assign data_o  = mem_q[rd_ptr_q[PTR_W-1:0]]; // Head is always visible.
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                     (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

    // The user must respect the flags.
    no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(wr_en_i && full_o)
    ) else $error("sync_fifo: write while full");

    no_read_when_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(rd_en_i && empty_o)
    ) else $error("sync_fifo: read while empty");

endmodule

//--- hdl/uart_rx.sv
`include "uart_defines.svh"

module uart_rx (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               rx_i,
    input  logic [`BAUD_W-1:0] baud_div_i,
    output logic [`BYTE_W-1:0] byte_o,
    output logic               byte_valid_o
);

    import uart_pkg::*;

    logic               rx_meta_q;
    logic               rx_sync_q;
    line_state_e        state_q;
    logic [`BAUD_W-1:0] cnt_q;
    logic [2:0]         bit_idx_q;
    logic [`BYTE_W-1:0] shift_q;
    logic               valid_q;
    logic               half_done;
    logic               bit_done;

    // Two flop synchronizer, idles high.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    assign half_done = (cnt_q + 1'b1 >= (baud_div_i >> 1));
    assign bit_done  = (cnt_q + 1'b1 >= baud_div_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= LN_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                LN_IDLE: begin
                    if (!rx_sync_q) begin
                        state_q <= LN_START;
                        cnt_q   <= '0;
                    end
                end
                LN_START: begin
                    if (half_done) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        state_q   <= rx_sync_q ? LN_IDLE : LN_DATA; // Glitch check.
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                LN_DATA: begin
                    if (bit_done) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= LN_STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                LN_STOP: begin
                    if (bit_done) begin
                        cnt_q   <= '0;
                        state_q <= LN_IDLE;
                        valid_q <= rx_sync_q; // Bad stop bit drops the byte.
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= LN_IDLE;
            endcase
        end
    end

    // Mid-bit samples, LSB first.
    always_ff @(posedge clk_i) begin
        if (state_q == LN_DATA && bit_done) begin
            shift_q <= {rx_sync_q, shift_q[`BYTE_W-1:1]};
        end
    end

    assign byte_o       = shift_q;
    assign byte_valid_o = valid_q;

endmodule

//--- hdl/uart_tx.sv
`include "uart_defines.svh"

module uart_tx (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               tx_en_i,
    input  logic               data_valid_i,
    input  logic [`BYTE_W-1:0] data_i,
    input  logic [`BAUD_W-1:0] baud_div_i,
    output logic               pop_o,
    output logic               tx_o,
    output logic               tx_ready_o
);

    import uart_pkg::*;

    line_state_e        state_q;
    logic [`BAUD_W-1:0] cnt_q;
    logic [2:0]         bit_idx_q;
    logic [`BYTE_W-1:0] shift_q;
    logic               tx_q;
    logic               bit_done;

    assign tx_ready_o = (state_q == LN_IDLE);
    assign pop_o      = tx_ready_o && tx_en_i && data_valid_i;
    assign bit_done   = (cnt_q + 1'b1 >= baud_div_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= LN_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            case (state_q)
                LN_IDLE: begin
                    if (pop_o) begin
                        state_q <= LN_START;
                        cnt_q   <= '0;
                        tx_q    <= 1'b0; // Start bit.
                    end
                end
                LN_START,
                LN_DATA: begin
                    if (bit_done) begin
                        cnt_q <= '0;
                        if (state_q == LN_START) begin
                            state_q   <= LN_DATA;
                            bit_idx_q <= '0;
                            tx_q      <= shift_q[0];
                        end else if (bit_idx_q == 3'd7) begin
                            state_q <= LN_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[0];
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                LN_STOP: begin
                    if (bit_done) begin
                        cnt_q   <= '0;
                        state_q <= LN_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= LN_IDLE;
            endcase
        end
    end

    // Bit zero always holds the next bit to drive.
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            shift_q <= data_i;
        end else if (bit_done && (state_q == LN_START || state_q == LN_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign tx_o = tx_q;

    pop_needs_data: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        pop_o |-> data_valid_i
    ) else $error("uart_tx: pop from empty FIFO");

endmodule

//--- hdl/uart_ctrl.sv
`include "uart_defines.svh"

module uart_ctrl (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  uart_pkg::bus_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    output logic [`DATA_W-1:0] resp_data_o,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    input  logic               rx_i,
    output logic               tx_o
);

    import uart_pkg::*;

    ctrl_state_e        state_q;
    ctrl_state_e        state_d;
    ctrl_reg_t          ctrl_q;
    ctrl_reg_t          ctrl_d;
    status_t            status;
    logic [`DATA_W-1:0] resp_data_q;
    logic [`DATA_W-1:0] resp_data_d;
    logic               resp_valid_q;
    logic               resp_valid_d;
    logic [`BYTE_W-1:0] wbuf_q;
    logic [`BYTE_W-1:0] wbuf_d;

    logic               in_window;
    reg_off_e           reg_off;
    logic               accept;

    logic [`BYTE_W-1:0] tx_fifo_wdata;
    logic               tx_fifo_wr_en;
    logic [`BYTE_W-1:0] tx_fifo_rdata;
    logic               tx_fifo_full;
    logic               tx_fifo_empty;
    logic               tx_pop;

    logic               rx_fifo_wr_en;
    logic               rx_fifo_rd_en;
    logic [`BYTE_W-1:0] rx_fifo_rdata;
    logic               rx_fifo_full;
    logic               rx_fifo_empty;
    logic [`BYTE_W-1:0] rx_byte;
    logic               rx_byte_valid;
    logic               rx_push;

    assign in_window = ((req_i.addr & ~`UART_MASK_ADDR) == `UART_BASE_ADDR);
    assign reg_off   = reg_off_e'(req_i.addr[`UART_OFF_W-1:0]);

    // No new request while busy or while a response is still held.
    assign req_ready_o = (state_q == ST_IDLE) && (!resp_valid_q || resp_ready_i);
    assign accept      = req_valid_i && req_ready_o;
    assign rx_push     = rx_byte_valid && ctrl_q.rx_en;

    assign status = '{
        rx_empty: rx_fifo_empty,
        rx_full:  rx_fifo_full,
        tx_empty: tx_fifo_empty,
        tx_full:  tx_fifo_full
    };

    always_comb begin
        state_d       = state_q;
        ctrl_d        = ctrl_q;
        resp_data_d   = resp_data_q;
        resp_valid_d  = resp_valid_q;
        wbuf_d        = wbuf_q;
        tx_fifo_wr_en = 1'b0;
        tx_fifo_wdata = req_i.wdata[`BYTE_W-1:0];
        rx_fifo_rd_en = 1'b0;
        rx_fifo_wr_en = 1'b0;

        if (resp_valid_q && resp_ready_i) begin
            resp_valid_d = 1'b0;
        end

        case (state_q)
            ST_IDLE: begin
                if (accept && in_window && req_i.write) begin
                    case (reg_off)
                        REG_CTRL: begin
                            ctrl_d      = ctrl_reg_t'(req_i.wdata);
                            ctrl_d.rsvd = '0;
                        end
                        REG_WDATA: begin
                            if (tx_fifo_full) begin
                                wbuf_d  = req_i.wdata[`BYTE_W-1:0];
                                state_d = ST_WAIT_SPACE;
                            end else begin
                                tx_fifo_wr_en = 1'b1;
                            end
                        end
                        default: ; // Read-only registers.
                    endcase
                end else if (accept && in_window) begin
                    case (reg_off)
                        REG_CTRL: begin
                            resp_data_d  = ctrl_q;
                            resp_valid_d = 1'b1;
                        end
                        REG_STATUS: begin
                            resp_data_d  = `DATA_W'(status);
                            resp_valid_d = 1'b1;
                        end
                        REG_RDATA: begin
                            if (rx_fifo_empty) begin
                                state_d = ST_WAIT_DATA;
                            end else begin
                                resp_data_d   = `DATA_W'(rx_fifo_rdata);
                                resp_valid_d  = 1'b1;
                                rx_fifo_rd_en = 1'b1;
                            end
                        end
                        default: begin
                            resp_data_d  = '0;
                            resp_valid_d = 1'b1;
                        end
                    endcase
                end
            end
            ST_WAIT_DATA: begin
                // FIFO may have been written in the cycle the read was taken.
                if (!rx_fifo_empty) begin
                    resp_data_d   = `DATA_W'(rx_fifo_rdata);
                    resp_valid_d  = 1'b1;
                    rx_fifo_rd_en = 1'b1;
                    state_d       = ST_IDLE;
                end else if (rx_push) begin
                    resp_data_d  = `DATA_W'(rx_byte); // Bypass the FIFO.
                    resp_valid_d = 1'b1;
                    state_d      = ST_IDLE;
                end
            end
            ST_WAIT_SPACE: begin
                tx_fifo_wdata = wbuf_q;
                if (!tx_fifo_full) begin
                    tx_fifo_wr_en = 1'b1;
                    state_d       = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase

        if (rx_push && state_q != ST_WAIT_DATA && !rx_fifo_full) begin
            rx_fifo_wr_en = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q      <= ST_IDLE;
            ctrl_q       <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            ctrl_q       <= ctrl_d;
            resp_valid_q <= resp_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        resp_data_q <= resp_data_d;
        wbuf_q      <= wbuf_d;
    end

    assign resp_data_o  = resp_data_q;
    assign resp_valid_o = resp_valid_q;

    sync_fifo #(
        .DATA_W (`BYTE_W),
        .DEPTH  (`FIFO_DEPTH)
    ) rx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .data_i  (rx_byte),
        .wr_en_i (rx_fifo_wr_en),
        .rd_en_i (rx_fifo_rd_en),
        .data_o  (rx_fifo_rdata),
        .full_o  (rx_fifo_full),
        .empty_o (rx_fifo_empty)
    );

    sync_fifo #(
        .DATA_W (`BYTE_W),
        .DEPTH  (`FIFO_DEPTH)
    ) tx_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .data_i  (tx_fifo_wdata),
        .wr_en_i (tx_fifo_wr_en),
        .rd_en_i (tx_pop),
        .data_o  (tx_fifo_rdata),
        .full_o  (tx_fifo_full),
        .empty_o (tx_fifo_empty)
    );

    uart_rx uart_rx_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rx_i         (rx_i),
        .baud_div_i   (ctrl_q.baud_div),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid)
    );

    uart_tx uart_tx_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .tx_en_i      (ctrl_q.tx_en),
        .data_valid_i (!tx_fifo_empty),
        .data_i       (tx_fifo_rdata),
        .baud_div_i   (ctrl_q.baud_div),
        .pop_o        (tx_pop),
        .tx_o         (tx_o),
        .tx_ready_o   ()
    );

    resp_held: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o)
    ) else $error("uart_ctrl: response changed before it was taken");

    idle_needs_request: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (state_q == ST_IDLE) && !accept |=> (state_q == ST_IDLE)
    ) else $error("uart_ctrl: left idle without a request");

endmodule

//--- dv/uart_checker.sv
`include "uart_defines.svh"

module uart_checker (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               tx_i,
    input  int                 baud_div_i,
    input  logic               resp_valid_i,
    input  logic               resp_ready_i,
    input  logic [`DATA_W-1:0] resp_data_i,
    output int                 tx_errs_o,
    output int                 resp_errs_o
);

    logic [`BYTE_W-1:0] exp_tx_q[$];
    string              tx_name_q[$];
    logic [`DATA_W-1:0] exp_resp_q[$];
    string              resp_name_q[$];

    logic [`BYTE_W-1:0] frame;
    logic [`BYTE_W-1:0] exp_byte;
    string              tx_name;
    logic [`DATA_W-1:0] exp_resp;
    string              resp_name;

    function automatic void expect_tx(input logic [`BYTE_W-1:0] value, input string test);
        exp_tx_q.push_back(value);
        tx_name_q.push_back(test);
    endfunction

    function automatic void expect_resp(input logic [`DATA_W-1:0] value, input string test);
        exp_resp_q.push_back(value);
        resp_name_q.push_back(test);
    endfunction

    // Bytes and responses still owed by the DUT.
    function automatic int outstanding();
        return exp_tx_q.size() + exp_resp_q.size();
    endfunction

    // Samples at mid-bit, on falling edges where the line is stable.
    initial begin : tx_decode
        tx_errs_o = 0;
        wait (rstn_i === 1'b1);
        forever begin
            @(negedge clk_i);
            if (tx_i === 1'b0) begin
                repeat (baud_div_i / 2) @(negedge clk_i);
                if (tx_i !== 1'b0) begin
                    tx_errs_o++;
                    $display("Start bit on the tx line ended before mid-bit");
                end
                for (int i = 0; i < `BYTE_W; i++) begin
                    repeat (baud_div_i) @(negedge clk_i);
                    frame[i] = tx_i; // LSB first.
                end
                repeat (baud_div_i) @(negedge clk_i);
                if (tx_i !== 1'b1) begin
                    tx_errs_o++;
                    $display("Stop bit on the tx line was low for byte %02h", frame);
                end
                if (exp_tx_q.size() == 0) begin
                    tx_errs_o++;
                    $display("Unexpected byte %02h appeared on the tx line", frame);
                end else begin
                    exp_byte = exp_tx_q.pop_front();
                    tx_name  = tx_name_q.pop_front();
                    if (frame !== exp_byte) begin
                        tx_errs_o++;
                        $display("Mismatch in %s: tx byte expected %02h, actual %02h",
                                 tx_name, exp_byte, frame);
                    end
                end
            end
        end
    end

    initial begin : resp_check
        resp_errs_o = 0;
        forever begin
            @(negedge clk_i);
            if (rstn_i === 1'b1 && resp_valid_i === 1'b1 && resp_ready_i === 1'b1) begin
                if (exp_resp_q.size() == 0) begin
                    resp_errs_o++;
                    $display("Unexpected response %08h with no read outstanding", resp_data_i);
                end else begin
                    exp_resp  = exp_resp_q.pop_front();
                    resp_name = resp_name_q.pop_front();
                    if (resp_data_i !== exp_resp) begin
                        resp_errs_o++;
                        $display("Mismatch in %s: response expected %08h, actual %08h",
                                 resp_name, exp_resp, resp_data_i);
                    end
                end
            end
        end
    end

endmodule

//--- dv/uart_tb.sv
`include "uart_defines.svh"

module uart_tb;

    import uart_pkg::*;

    localparam int BAUD_DIV       = 8;
    localparam int FRAME_CYCLES   = 10 * BAUD_DIV;
    localparam int MAX_BYTES      = 80;
    localparam int TRAFFIC_CYCLES = 13600; // Register traffic, reset and idle gaps.
    localparam int TIMEOUT_CYCLES = MAX_BYTES * FRAME_CYCLES + TRAFFIC_CYCLES;

    logic               clk;
    logic               rstn;
    bus_req_t           req;
    logic               req_valid;
    logic               req_ready;
    logic [`DATA_W-1:0] resp_data;
    logic               resp_valid;
    logic               resp_ready;
    logic               line; // Loopback.
    logic               random_ready;
    int                 baud_div;
    int                 cycles;
    int                 tb_errs;
    int                 tx_errs;
    int                 resp_errs;
    int                 waited;
    string              test_name;
    logic [`DATA_W-1:0] model_ctrl;
    logic [`BYTE_W-1:0] tx_model_q[$];
    logic [`BYTE_W-1:0] rx_model_q[$];

    uart_ctrl uart_ctrl_i (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .resp_data_o  (resp_data),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .rx_i         (line),
        .tx_o         (line)
    );

    uart_checker uart_checker_i (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .tx_i         (line),
        .baud_div_i   (baud_div),
        .resp_valid_i (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_data_i  (resp_data),
        .tx_errs_o    (tx_errs),
        .resp_errs_o  (resp_errs)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        #1;
        resp_ready = random_ready ? 1'($urandom) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("Test failures found");
            $finish;
        end
    end

    // Register file and FIFO model.
    function automatic logic [`DATA_W-1:0] expected_read(input reg_off_e off);
        case (off)
            REG_CTRL:   return model_ctrl;
            REG_STATUS: return {28'd0, rx_model_q.size() == 0, rx_model_q.size() == `FIFO_DEPTH,
                                tx_model_q.size() == 0, tx_model_q.size() == `FIFO_DEPTH};
            REG_RDATA:  return {24'd0, rx_model_q[0]};
            default:    return '0;
        endcase
    endfunction

    task automatic report_counts();
        $display("Error counts: tx %0d, response %0d, bus %0d", tx_errs, resp_errs, tb_errs);
    endtask

    // Holds the request until it is taken, sampling ready on the falling edge.
    task automatic bus_request(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] wdata,
                               input logic write);
        logic taken;
        req.addr  = addr;
        req.wdata = wdata;
        req.write = write;
        req_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic write_ctrl(input logic [`DATA_W-1:0] value);
        bus_request(`UART_BASE_ADDR | `ADDR_W'(REG_CTRL), value, 1'b1);
        model_ctrl = value & 32'hFFFF_0003;
        baud_div   = int'(value[31:16]);
    endtask

    task automatic send_byte(input logic [`BYTE_W-1:0] value);
        bus_request(`UART_BASE_ADDR | `ADDR_W'(REG_WDATA), {24'd0, value}, 1'b1);
        tx_model_q.push_back(value);
        if (model_ctrl[1]) begin
            rx_model_q.push_back(value); // Comes back over the loopback.
        end
        uart_checker_i.expect_tx(value, test_name);
    endtask

    task automatic read_reg(input reg_off_e off);
        logic [`DATA_W-1:0] exp;
        exp = expected_read(off);
        if (off == REG_RDATA) begin
            void'(rx_model_q.pop_front());
        end
        uart_checker_i.expect_resp(exp, test_name);
        bus_request(`UART_BASE_ADDR | `ADDR_W'(off), '0, 1'b0);
    endtask

    task automatic wait_drain();
        while (uart_checker_i.outstanding() != 0) begin
            @(negedge clk);
        end
        repeat (BAUD_DIV) @(posedge clk); // Rest of the last stop bit.
        #1;
        tx_model_q.delete();
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        resp_ready   = 1'b1;
        random_ready = 1'b0;
        baud_div     = 0;
        cycles       = 0;
        tb_errs      = 0;
        model_ctrl   = '0;
        test_name    = "reset";
        void'($urandom(32'hec37));
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_name = "reset_values";
        read_reg(REG_STATUS);
        read_reg(REG_CTRL);
        wait_drain();

        test_name = "tx_only";
        write_ctrl({16'(BAUD_DIV), 14'd0, 1'b0, 1'b1});
        read_reg(REG_CTRL);
        repeat (10) send_byte(8'($urandom));
        wait_drain();

        test_name = "loopback_backpressure";
        write_ctrl({16'(BAUD_DIV), 14'd0, 1'b1, 1'b1});
        repeat (10) send_byte(8'($urandom));
        random_ready = 1'b1;
        repeat (10) read_reg(REG_RDATA);
        wait_drain();
        random_ready = 1'b0;

        // Byte goes out first, the read is taken while it is still on the line.
        test_name = "rdata_wait";
        send_byte(8'($urandom));
        read_reg(REG_RDATA);
        waited = 0;
        @(negedge clk);
        while (resp_valid !== 1'b1) begin
            if (req_ready !== 1'b0) begin
                tb_errs++;
                $display("req_ready_o was high while an RDATA read waited for data");
            end
            waited++;
            @(negedge clk);
        end
        if (waited < BAUD_DIV) begin
            tb_errs++;
            $display("RDATA read returned before the byte could have arrived");
        end
        wait_drain();

        test_name = "tx_fifo_full";
        write_ctrl({16'(BAUD_DIV), 16'd0});
        repeat (`FIFO_DEPTH) send_byte(8'($urandom));
        read_reg(REG_STATUS);
        write_ctrl({16'(BAUD_DIV), 14'd0, 1'b0, 1'b1});
        send_byte(8'($urandom)); // Taken while the FIFO is still full.
        @(negedge clk);
        if (req_ready !== 1'b0) begin
            tb_errs++;
            $display("Write to a full TX FIFO did not wait for space");
        end
        @(posedge clk);
        #1;
        wait_drain();

        test_name = "outside_window";
        read_reg(REG_STATUS);
        bus_request(32'h3000_000C, 32'($urandom), 1'b1);
        repeat (3 * FRAME_CYCLES) @(posedge clk);
        #1;
        read_reg(REG_STATUS);
        wait_drain();

        report_counts();
        if (tb_errs + tx_errs + resp_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/sync_fifo.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_ctrl.sv
dv/uart_checker.sv
dv/uart_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module uart_tb -o uart_sim

./obj_dir/uart_sim | tee sim.log

grep -q "All tests passed!" sim.log
